/* logic/exec_cfg.svh */
`ifndef EXEC_CFG_SVH
`define EXEC_CFG_SVH

// Operand and result width, one machine word
`define EXEC_WIDTH 32

// Overflow, above, equal, below, between, collision, error
`define FLAG_COUNT 7

// BFJ operand layout inside data2
`define BFJ_MASK_LSB  0    // Flag select bits 0 to 6
`define BFJ_VALUE_LSB 7    // Required values in bits 7 to 13

`endif

/* logic/execPkg.sv */
`include "exec_cfg.svh"

package execPkg;

    // ALU opcodes, code 0 left unnamed and treated as invalid
    typedef enum logic [3:0] {
        ALU_ADD = 4'd1,
        ALU_SUB = 4'd2,
        ALU_MUL = 4'd3,
        ALU_DIV = 4'd4,
        ALU_MOV = 4'd5,
        ALU_SLW = 4'd6,
        ALU_AND = 4'd7,
        ALU_OR  = 4'd8,
        ALU_SHL = 4'd9,
        ALU_SHR = 4'd10,
        ALU_CMP = 4'd11,
        ALU_NOT = 4'd12,
        ALU_JMP = 4'd13,
        ALU_BFJ = 4'd14,
        ALU_NOP = 4'd15
    } aluOp_e;

    // Condition flags, overflow is the MSB and error bit 0
    typedef struct packed {
        logic overflow;
        logic above;
        logic equal;
        logic below;
        logic between;     // Set from outside only
        logic collision;   // Set from outside only
        logic error;
    } aluFlags_t;

    typedef struct packed {
        aluOp_e                         op;
        logic signed [`EXEC_WIDTH-1:0]  data1;
        logic signed [`EXEC_WIDTH-1:0]  data2;
    } issueReq_t;

    typedef struct packed {
        logic signed [`EXEC_WIDTH-1:0]  result;
        logic                           zero;    // Branch taken
        aluFlags_t                      flags;
    } execResp_t;

endpackage

/* logic/aluCore.sv */
`timescale 1ns/1ps
`include "exec_cfg.svh"

module aluCore (
    input  execPkg::issueReq_t  req,
    input  execPkg::aluFlags_t  storedFlags,
    output execPkg::execResp_t  resp
);
    import execPkg::*;

    logic signed [`EXEC_WIDTH-1:0]   a;
    logic signed [`EXEC_WIDTH-1:0]   b;
    logic signed [2*`EXEC_WIDTH-1:0] product;
    logic [`FLAG_COUNT-1:0]          flagVec;     // Stored flags, error at bit 0
    logic                            match;
    logic signed [`EXEC_WIDTH-1:0]   resultVal;
    logic                            zeroOut;
    aluFlags_t                       flagsOut;

    assign a       = req.data1;
    assign b       = req.data2;
    assign product = a * b;          // Full-width signed product
    assign flagVec = storedFlags;

    // BFJ test: every selected flag must equal its value bit
    always_comb begin
        match = 1'b1;
        for (int i = 0; i < `FLAG_COUNT; i++) begin
            if (b[`BFJ_MASK_LSB + i] && (flagVec[i] != b[`BFJ_VALUE_LSB + i])) begin
                match = 1'b0;
            end
        end
    end

    always_comb begin
        resultVal = '0;
        zeroOut   = 1'b0;
        flagsOut  = '0;

        case (req.op)
            ALU_ADD: begin
                resultVal = a + b;
                // Same input signs, different result sign
                flagsOut.overflow = (a[`EXEC_WIDTH-1] == b[`EXEC_WIDTH-1]) &&
                                    (resultVal[`EXEC_WIDTH-1] != a[`EXEC_WIDTH-1]);
            end

            ALU_SUB: begin
                resultVal = a - b;
                flagsOut.overflow = (a[`EXEC_WIDTH-1] != b[`EXEC_WIDTH-1]) &&
                                    (resultVal[`EXEC_WIDTH-1] != a[`EXEC_WIDTH-1]);
            end

            ALU_MUL: begin
                resultVal = product[`EXEC_WIDTH-1:0];
                // Upper half plus sign bit must be a pure sign extension
                flagsOut.overflow = product[2*`EXEC_WIDTH-1:`EXEC_WIDTH-1] !=
                                    {(`EXEC_WIDTH+1){product[2*`EXEC_WIDTH-1]}};
            end

            ALU_DIV: begin
                if (b == 0) begin
                    resultVal      = '0;
                    flagsOut.error = 1'b1;     // Divide by zero
                end else begin
                    resultVal = a / b;
                end
            end

            ALU_MOV: resultVal = a;

            ALU_SLW: resultVal = b;

            ALU_AND: resultVal = a & b;

            ALU_OR: resultVal = a | b;

            ALU_NOT: resultVal = ~b;

            ALU_SHL: resultVal = b << $unsigned(a);

            ALU_SHR: resultVal = b >>> $unsigned(a);   // Keeps the sign of data2

            ALU_CMP: begin
                // Exactly one of the three, signed compare
                if (a == b) begin
                    flagsOut.equal = 1'b1;
                end else if (a > b) begin
                    flagsOut.above = 1'b1;
                end else begin
                    flagsOut.below = 1'b1;
                end
            end

            ALU_JMP: zeroOut = 1'b1;

            ALU_BFJ: zeroOut = match;

            ALU_NOP: begin
                resultVal = '0;
                zeroOut   = 1'b1;
            end

            default: begin
                // Unknown opcode behaves as a taken branch with error
                resultVal      = '0;
                zeroOut        = 1'b1;
                flagsOut.error = 1'b1;
            end
        endcase
    end

    assign resp = '{result: resultVal, zero: zeroOut, flags: flagsOut};

endmodule

/* logic/flagStore.sv */
`timescale 1ns/1ps

module flagStore (
    input  logic                clk,
    input  logic                rstN,
    input  logic                issueValid,
    input  execPkg::aluOp_e     op,
    input  execPkg::aluFlags_t  newFlags,
    input  logic                flagsWrite,
    input  execPkg::aluFlags_t  flagsIn,
    output execPkg::aluFlags_t  storedFlags
);
    import execPkg::*;

    logic updatesFlags;

    // Arithmetic, compare and invalid codes refresh the flags
    always_comb begin
        case (op)
            ALU_ADD, ALU_SUB, ALU_MUL, ALU_DIV, ALU_CMP: begin
                updatesFlags = 1'b1;
            end
            ALU_MOV, ALU_SLW, ALU_AND, ALU_OR, ALU_NOT,
            ALU_SHL, ALU_SHR, ALU_JMP, ALU_BFJ, ALU_NOP: begin
                updatesFlags = 1'b0;
            end
            default: begin
                updatesFlags = 1'b1;     // Invalid opcode records its error
            end
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            storedFlags <= '0;
        end else if (flagsWrite) begin
            storedFlags <= flagsIn;      // External write beats the ALU
        end else if (issueValid && updatesFlags) begin
            storedFlags <= newFlags;
        end
    end

endmodule

/* logic/execOutReg.sv */
`timescale 1ns/1ps

module execOutReg (
    input  logic                clk,
    input  logic                rstN,
    input  logic                issueValid,
    input  execPkg::execResp_t  aluResp,
    output logic                done,
    output execPkg::execResp_t  resp
);

    // One-cycle done pulse per issue
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            done <= 1'b0;
        end else begin
            done <= issueValid;
        end
    end

    // Response holds until the next issue overwrites it
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            resp <= '0;
        end else if (issueValid) begin
            resp <= aluResp;
        end
    end

endmodule

/* logic/execUnit.sv */
`timescale 1ns/1ps

module execUnit (
    input  logic                clk,
    input  logic                rstN,
    input  logic                issueValid,
    input  execPkg::issueReq_t  issueReq,
    input  logic                flagsWrite,
    input  execPkg::aluFlags_t  flagsIn,
    output logic                done,
    output execPkg::execResp_t  resp,
    output execPkg::aluFlags_t  storedFlags
);
    import execPkg::*;

    execResp_t aluResp;     // Combinational ALU answer for the current issue

    aluCore u_aluCore (
        .req         (issueReq),
        .storedFlags (storedFlags),
        .resp        (aluResp)
    );

    // Flags land on the same edge as done
    flagStore u_flagStore (
        .clk         (clk),
        .rstN        (rstN),
        .issueValid  (issueValid),
        .op          (issueReq.op),
        .newFlags    (aluResp.flags),
        .flagsWrite  (flagsWrite),
        .flagsIn     (flagsIn),
        .storedFlags (storedFlags)
    );

    execOutReg u_execOutReg (
        .clk         (clk),
        .rstN        (rstN),
        .issueValid  (issueValid),
        .aluResp     (aluResp),
        .done        (done),
        .resp        (resp)
    );

endmodule

/* test/execUnit_properties.sv */
`timescale 1ns/1ps

module execUnit_properties (
    input  logic                clk,
    input  logic                rstN,
    input  logic                issueValid,
    input  execPkg::issueReq_t  issueReq,
    input  logic                flagsWrite,
    input  logic                done,
    input  execPkg::aluFlags_t  storedFlags
);
    import execPkg::*;

    logic updatesFlags;
    int   assertFails = 0;

    // Everything outside the move, logic and branch group refreshes flags
    assign updatesFlags = !(issueReq.op inside {ALU_MOV, ALU_SLW, ALU_AND, ALU_OR, ALU_NOT,
                                                ALU_SHL, ALU_SHR, ALU_JMP, ALU_BFJ, ALU_NOP});

    doneAfterIssue: assert property (@(posedge clk) disable iff (!rstN)
        issueValid |=> done)
        else begin
            $error("done missing one cycle after an issue");
            assertFails++;
        end

    noDoneWithoutIssue: assert property (@(posedge clk) disable iff (!rstN)
        !issueValid |=> !done)
        else begin
            $error("done high without an issue the cycle before");
            assertFails++;
        end

    clearAfterReset: assert property (@(posedge clk)
        $rose(rstN) |-> (!done && storedFlags == '0))
        else begin
            $error("done or storedFlags not cleared by reset");
            assertFails++;
        end

    flagsHold: assert property (@(posedge clk) disable iff (!rstN)
        (!flagsWrite && !(issueValid && updatesFlags)) |=> $stable(storedFlags))
        else begin
            $error("storedFlags changed with no write and no flag update");
            assertFails++;
        end

endmodule

bind execUnit execUnit_properties props (
    .clk         (clk),
    .rstN        (rstN),
    .issueValid  (issueValid),
    .issueReq    (issueReq),
    .flagsWrite  (flagsWrite),
    .done        (done),
    .storedFlags (storedFlags)
);

/* test/execUnit_tb.sv */
`timescale 1ns/1ps
`include "exec_cfg.svh"

module execUnit_tb;
    import execPkg::*;

    // One table row: stimulus, optional flag write, expected response
    typedef struct packed {
        aluOp_e                  op;
        logic [`EXEC_WIDTH-1:0]  data1;
        logic [`EXEC_WIDTH-1:0]  data2;
        logic                    writeFlags;
        aluFlags_t               flagsIn;
        logic [`EXEC_WIDTH-1:0]  result;
        logic                    zero;
        aluFlags_t               flags;
        aluFlags_t               stored;
    } testRow_t;

    localparam aluFlags_t fNone    = 7'b0000000;
    localparam aluFlags_t fOvf     = 7'b1000000;
    localparam aluFlags_t fAbove   = 7'b0100000;
    localparam aluFlags_t fEqual   = 7'b0010000;
    localparam aluFlags_t fBelow   = 7'b0001000;
    localparam aluFlags_t fBetween = 7'b0000100;
    localparam aluFlags_t fColl    = 7'b0000010;
    localparam aluFlags_t fErr     = 7'b0000001;

    localparam int numRandom = 40;
    localparam longint wordMax = 64'sd2147483647;
    localparam longint wordMin = -64'sd2147483648;

    logic       clk = 1'b0;
    logic       rstN;
    logic       issueValid;
    issueReq_t  issueReq;
    logic       flagsWrite;
    aluFlags_t  flagsIn;
    logic       done;
    execResp_t  resp;
    aluFlags_t  storedFlags;

    testRow_t   rows[$];
    string      rowNames[$];
    aluOp_e     randomOpSet[4] = '{ALU_ADD, ALU_SUB, ALU_AND, ALU_CMP};
    integer     seed;
    int         errorCount = 0;
    int         passCount = 0;
    int         failCount = 0;
    int         testNum = 0;
    int         cycleCount = 0;
    int         cycleLimit = 0;

    execUnit dut (
        .clk         (clk),
        .rstN        (rstN),
        .issueValid  (issueValid),
        .issueReq    (issueReq),
        .flagsWrite  (flagsWrite),
        .flagsIn     (flagsIn),
        .done        (done),
        .resp        (resp),
        .storedFlags (storedFlags)
    );

    always #50 clk = ~clk;      // 100 ns period

    // Run guard against a stuck DUT
    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleLimit > 0 && cycleCount >= cycleLimit) begin
            $display("Timeout: run went past %0d cycles without finishing", cycleLimit);
            $display("Simulation FAILED");
            $finish;
        end
    end

    task automatic checkField(input string sigName, input logic [`EXEC_WIDTH-1:0] expVal,
                              input logic [`EXEC_WIDTH-1:0] gotVal);
        assert (gotVal === expVal) else begin
            $display("Error at %0d ns: %s expected %h, got %h", $time, sigName, expVal, gotVal);
            errorCount++;
        end
    endtask

    task automatic finishTest(input string name, input int errorsBefore);
        testNum++;
        if (errorCount == errorsBefore) begin
            passCount++;
            $display("Test %0d %s: passed", testNum, name);
        end else begin
            failCount++;
            $display("Test %0d %s: failed", testNum, name);
        end
    endtask

    task automatic addWriteRow(input string name, input aluOp_e op,
                               input logic [`EXEC_WIDTH-1:0] d1, input logic [`EXEC_WIDTH-1:0] d2,
                               input logic wr, input aluFlags_t wrFlags,
                               input logic [`EXEC_WIDTH-1:0] res, input logic z,
                               input aluFlags_t fl, input aluFlags_t st);
        rows.push_back({op, d1, d2, wr, wrFlags, res, z, fl, st});
        rowNames.push_back(name);
    endtask

    task automatic addRow(input string name, input aluOp_e op,
                          input logic [`EXEC_WIDTH-1:0] d1, input logic [`EXEC_WIDTH-1:0] d2,
                          input logic [`EXEC_WIDTH-1:0] res, input logic z,
                          input aluFlags_t fl, input aluFlags_t st);
        addWriteRow(name, op, d1, d2, 1'b0, fNone, res, z, fl, st);
    endtask

    // Last column tracks the flag register from row to row
    task automatic buildTable();
        addRow("ADD small", ALU_ADD, 32'd5, 32'd7, 32'd12, 1'b0, fNone, fNone);
        addRow("ADD overflow", ALU_ADD, 32'h7FFFFFFF, 32'h1, 32'h80000000, 1'b0, fOvf, fOvf);
        addRow("ADD negative", ALU_ADD, 32'hFFFFFFFE, 32'hFFFFFFFD, 32'hFFFFFFFB, 1'b0,
               fNone, fNone);
        addRow("SUB small", ALU_SUB, 32'd10, 32'd3, 32'd7, 1'b0, fNone, fNone);
        addRow("SUB overflow", ALU_SUB, 32'h80000000, 32'h1, 32'h7FFFFFFF, 1'b0, fOvf, fOvf);
        addRow("MUL signed", ALU_MUL, 32'd6, 32'hFFFFFFF9, 32'hFFFFFFD6, 1'b0, fNone, fNone);
        addRow("MUL overflow", ALU_MUL, 32'h00010000, 32'h00010000, 32'h0, 1'b0, fOvf, fOvf);
        addRow("DIV", ALU_DIV, 32'd100, 32'd7, 32'd14, 1'b0, fNone, fNone);
        addRow("DIV negative", ALU_DIV, 32'hFFFFFFF7, 32'd2, 32'hFFFFFFFC, 1'b0, fNone, fNone);
        addRow("DIV by zero", ALU_DIV, 32'd5, 32'd0, 32'd0, 1'b0, fErr, fErr);
        // Moves and logic keep the error flag from the division above
        addRow("MOV", ALU_MOV, 32'h12345678, 32'h0000FFFF, 32'h12345678, 1'b0, fNone, fErr);
        addRow("SLW", ALU_SLW, 32'h1, 32'hCAFE0000, 32'hCAFE0000, 1'b0, fNone, fErr);
        addRow("AND", ALU_AND, 32'hF0F0F0F0, 32'hFF00FF00, 32'hF000F000, 1'b0, fNone, fErr);
        addRow("OR", ALU_OR, 32'hF0F0F0F0, 32'h0F0000FF, 32'hFFF0F0FF, 1'b0, fNone, fErr);
        addRow("NOT", ALU_NOT, 32'h0, 32'h0000FFFF, 32'hFFFF0000, 1'b0, fNone, fErr);
        addRow("SHL", ALU_SHL, 32'd4, 32'h00000123, 32'h00001230, 1'b0, fNone, fErr);
        addRow("SHR negative", ALU_SHR, 32'd8, 32'h80001000, 32'hFF800010, 1'b0, fNone, fErr);
        addRow("CMP equal", ALU_CMP, 32'd5, 32'd5, 32'd0, 1'b0, fEqual, fEqual);
        addRow("BFJ equal match", ALU_BFJ, 32'd0, 32'h00000810, 32'd0, 1'b1, fNone, fEqual);
        addRow("BFJ above mismatch", ALU_BFJ, 32'd0, 32'h00001020, 32'd0, 1'b0, fNone, fEqual);
        addRow("CMP greater", ALU_CMP, 32'd9, 32'hFFFFFFFD, 32'd0, 1'b0, fAbove, fAbove);
        addRow("BFJ two flags", ALU_BFJ, 32'd0, 32'h00001030, 32'd0, 1'b1, fNone, fAbove);
        addRow("CMP smaller", ALU_CMP, 32'hFFFFFFEC, 32'd3, 32'd0, 1'b0, fBelow, fBelow);
        addRow("BFJ empty mask", ALU_BFJ, 32'd0, 32'd0, 32'd0, 1'b1, fNone, fBelow);
        addRow("JMP", ALU_JMP, 32'd0, 32'd0, 32'd0, 1'b1, fNone, fBelow);
        addWriteRow("Flag write", ALU_NOP, 32'd0, 32'd0, 1'b1, fBetween | fColl,
                    32'd0, 1'b1, fNone, fBetween | fColl);
        addRow("BFJ between collision", ALU_BFJ, 32'd0, 32'h00000306, 32'd0, 1'b1,
               fNone, fBetween | fColl);
        addWriteRow("Write beats CMP", ALU_CMP, 32'd1, 32'd2, 1'b1, fBetween,
                    32'd0, 1'b0, fBelow, fBetween);
        addRow("BFJ between only", ALU_BFJ, 32'd0, 32'h00000206, 32'd0, 1'b1, fNone, fBetween);
        addRow("NOP", ALU_NOP, 32'd0, 32'd0, 32'd0, 1'b1, fNone, fBetween);
        addRow("Invalid opcode", aluOp_e'(4'd0), 32'd3, 32'd4, 32'd0, 1'b1, fErr, fErr);
    endtask

    // Independent model for the random phase ops
    function automatic execResp_t refModel(input aluOp_e op,
                                           input logic signed [`EXEC_WIDTH-1:0] a,
                                           input logic signed [`EXEC_WIDTH-1:0] b);
        execResp_t r;
        longint    wide;
        r = '0;
        case (op)
            ALU_ADD, ALU_SUB: begin
                wide = (op == ALU_ADD) ? longint'(a) + longint'(b) : longint'(a) - longint'(b);
                r.result = wide[`EXEC_WIDTH-1:0];
                r.flags.overflow = (wide > wordMax) || (wide < wordMin);
            end
            ALU_AND: r.result = a & b;
            ALU_CMP: begin
                r.flags.equal = (a == b);
                r.flags.above = (a > b);
                r.flags.below = (a < b);
            end
            default: r = '0;
        endcase
        return r;
    endfunction

    task automatic runRow(input int idx);
        testRow_t r;
        int       errorsBefore;
        int       waited;
        r = rows[idx];
        errorsBefore = errorCount;
        waited = 0;
        @(posedge clk);
        issueValid <= 1'b1;
        issueReq   <= '{op: r.op, data1: r.data1, data2: r.data2};
        flagsWrite <= r.writeFlags;
        flagsIn    <= r.flagsIn;
        @(negedge clk);
        checkField("done", 1'b0, done);     // No early pulse
        @(posedge clk);
        issueValid <= 1'b0;
        flagsWrite <= 1'b0;
        do begin
            @(negedge clk);
            waited++;
        end while (!done && waited < 4);
        assert (done) else begin
            $display("Error at %0d ns: no done pulse after issuing %s", $time, rowNames[idx]);
            errorCount++;
        end
        assert (waited == 1) else begin
            $display("Error at %0d ns: done came %0d cycles after the issue instead of one",
                     $time, waited);
            errorCount++;
        end
        checkField("resp.result", r.result, resp.result);
        checkField("resp.zero", r.zero, resp.zero);
        checkField("resp.flags", r.flags, resp.flags);
        checkField("storedFlags", r.stored, storedFlags);
        finishTest(rowNames[idx], errorsBefore);
    endtask

    // Back-to-back issue, each answer checked while the next op is sampled
    task automatic runRandom();
        execResp_t  expQ[$];
        aluFlags_t  storedQ[$];
        aluFlags_t  modelFlags;
        execResp_t  expResp;
        aluFlags_t  expStored;
        aluOp_e     op;
        logic signed [`EXEC_WIDTH-1:0] a;
        logic signed [`EXEC_WIDTH-1:0] b;
        int         errorsBefore;
        errorsBefore = errorCount;
        modelFlags = rows[rows.size()-1].stored;
        for (int i = 0; i <= numRandom; i++) begin
            @(posedge clk);
            if (i < numRandom) begin
                op = randomOpSet[$unsigned($random(seed)) % 4];
                a  = $random(seed);
                b  = $random(seed);
                if (op == ALU_CMP && ($unsigned($random(seed)) % 4) == 0) begin
                    b = a;      // Hit the equal case now and then
                end
                issueValid <= 1'b1;
                issueReq   <= '{op: op, data1: a, data2: b};
                expResp = refModel(op, a, b);
                if (op != ALU_AND) begin
                    modelFlags = expResp.flags;
                end
                expQ.push_back(expResp);
                storedQ.push_back(modelFlags);
            end else begin
                issueValid <= 1'b0;
            end
            @(negedge clk);
            if (i > 0) begin
                expResp   = expQ.pop_front();
                expStored = storedQ.pop_front();
                checkField("done", 1'b1, done);
                checkField("resp.result", expResp.result, resp.result);
                checkField("resp.zero", expResp.zero, resp.zero);
                checkField("resp.flags", expResp.flags, resp.flags);
                checkField("storedFlags", expStored, storedFlags);
            end
        end
        @(negedge clk);
        checkField("done", 1'b0, done);     // Pulse ends with the last issue
        finishTest("Random back-to-back", errorsBefore);
    endtask

    initial begin
        int errorsBefore;
        rstN       = 1'b0;
        issueValid = 1'b0;
        issueReq   = '0;
        flagsWrite = 1'b0;
        flagsIn    = '0;
        seed       = 32'h6054_5934;
        buildTable();
        cycleLimit = (rows.size() + numRandom + 8) * 2;

        repeat (8) @(posedge clk);
        rstN <= 1'b1;

        @(negedge clk);
        errorsBefore = errorCount;
        checkField("done", 1'b0, done);
        checkField("resp.result", '0, resp.result);
        checkField("resp.zero", 1'b0, resp.zero);
        checkField("resp.flags", fNone, resp.flags);
        checkField("storedFlags", fNone, storedFlags);
        finishTest("Reset state", errorsBefore);

        foreach (rows[i]) begin
            runRow(i);
        end
        runRandom();

        errorCount += dut.props.assertFails;
        $display("Tests passed: %0d, tests failed: %0d, errors: %0d",
                 passCount, failCount, errorCount);
        if (failCount == 0 && errorCount == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

/* aluExec.f */
+incdir+logic
logic/execPkg.sv
logic/aluCore.sv
logic/flagStore.sv
logic/execOutReg.sv
logic/execUnit.sv
test/execUnit_properties.sv
test/execUnit_tb.sv

/* Bender.yml */
package:
  name: aluExec

sources:
  - include_dirs:
      - logic
    files:
      - logic/execPkg.sv
      - logic/aluCore.sv
      - logic/flagStore.sv
      - logic/execOutReg.sv
      - logic/execUnit.sv

  - target: test
    include_dirs:
      - logic
    files:
      - test/execUnit_properties.sv
      - test/execUnit_tb.sv
